// ==== wht_mem_pkg.sv ====
//------------------------------------------------
// Shared sizes and types for the 16-point WHT
// data memory. Compiled before every other file.
//------------------------------------------------

package wht_mem_pkg;

	//------------------------------------------------
	// Frame and RAM geometry
	//------------------------------------------------
	// Points per frame
	localparam int N_PTS = 16;
	// RAM address width
	localparam int ADDR_W = 4;
	// Radix-2 passes, log2 of N_PTS
	localparam int N_STAGES = 4;

	//------------------------------------------------
	// Data widths
	//------------------------------------------------
	// Input sample width
	localparam int IN_W = 16;
	// One bit of growth per pass keeps the transform exact
	localparam int WORD_W = IN_W + N_STAGES;

	// Idle cycles tolerated inside a partial frame
	localparam int SINK_TIMEOUT = 32;

	typedef logic signed [IN_W-1:0] in_sample_t;
	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Top level phase sequencer
	typedef enum logic [1:0] {
		IDLE,
		SINK,
		STAGES,
		SOURCE
	} seq_state_t;

endpackage

// ==== wht_sample_ram.sv ====
//------------------------------------------------
// Shared 16-word sample RAM. One write port and
// one registered read port on the same clock.
//------------------------------------------------
`timescale 1ns/1ps

module wht_sample_ram (
	input  logic               clk,
	input  logic               we,
	input  wht_mem_pkg::addr_t waddr,
	input  wht_mem_pkg::word_t wdata,
	input  wht_mem_pkg::addr_t raddr,
	output wht_mem_pkg::word_t rdata
);

	import wht_mem_pkg::*;

	// Storage, contents undefined after reset
	word_t mem [N_PTS];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read data one cycle after the address
	// old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== wht_mem_arbiter.sv ====
//------------------------------------------------
// Four-phase req/ack arbiter for the sample RAM.
// Fixed priority sink, engine, source. The owner's
// lines reach the RAM and no one else's do.
//------------------------------------------------
`timescale 1ns/1ps

module wht_mem_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	// Sink writer
	input  logic               sink_req,
	output logic               sink_ack,
	input  logic               sink_we,
	input  wht_mem_pkg::addr_t sink_waddr,
	input  wht_mem_pkg::word_t sink_wdata,
	input  wht_mem_pkg::addr_t sink_raddr,
	// Stage engine
	input  logic               eng_req,
	output logic               eng_ack,
	input  logic               eng_we,
	input  wht_mem_pkg::addr_t eng_waddr,
	input  wht_mem_pkg::word_t eng_wdata,
	input  wht_mem_pkg::addr_t eng_raddr,
	// Source reader
	input  logic               src_req,
	output logic               src_ack,
	input  logic               src_we,
	input  wht_mem_pkg::addr_t src_waddr,
	input  wht_mem_pkg::word_t src_wdata,
	input  wht_mem_pkg::addr_t src_raddr,
	// RAM side
	output logic               we,
	output wht_mem_pkg::addr_t waddr,
	output wht_mem_pkg::word_t wdata,
	output wht_mem_pkg::addr_t raddr
);

	import wht_mem_pkg::*;

	// One-hot owner, bit order sink, engine, source
	logic [2:0] owner;

	assign sink_ack = owner[0];
	assign eng_ack  = owner[1];
	assign src_ack  = owner[2];

	//------------------------------------------------
	// Grant and release
	//------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner <= '0;
		end else if (|owner) begin
			// Owner keeps the RAM until its req falls
			// ack then drops on this edge
			owner <= owner & {src_req, eng_req, sink_req};
		end else begin
			// Free and ack low, grant by priority
			owner[0] <= sink_req;
			owner[1] <= eng_req & ~sink_req;
			owner[2] <= src_req & ~sink_req & ~eng_req;
		end
	end

	//------------------------------------------------
	// RAM port mux
	//------------------------------------------------
	always_comb begin
		we    = 1'b0;
		waddr = '0;
		wdata = '0;
		raddr = '0;
		case (owner)
			3'b001: begin
				we    = sink_we;
				waddr = sink_waddr;
				wdata = sink_wdata;
				raddr = sink_raddr;
			end
			3'b010: begin
				we    = eng_we;
				waddr = eng_waddr;
				wdata = eng_wdata;
				raddr = eng_raddr;
			end
			3'b100: begin
				we    = src_we;
				waddr = src_waddr;
				wdata = src_wdata;
				raddr = src_raddr;
			end
			// No owner, write stays off
			default: ;
		endcase
	end

endmodule

// ==== wht_sink.sv ====
//------------------------------------------------
// Sink writer. Collects one frame of samples into
// the RAM in natural order, abandons a frame that
// stalls for SINK_TIMEOUT cycles.
//------------------------------------------------
`timescale 1ns/1ps

module wht_sink (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    in_valid,
	input  logic                    in_sop,
	input  wht_mem_pkg::in_sample_t in_data,
	output logic                    req,
	input  logic                    ack,
	output logic                    we,
	output wht_mem_pkg::addr_t      waddr,
	output wht_mem_pkg::word_t      wdata,
	output logic                    done,
	output logic                    abort
);

	import wht_mem_pkg::*;

	logic       active;
	logic       fin;
	logic       req_q;
	logic       wr_pend;
	addr_t      cnt;
	addr_t      addr;
	logic       accept;
	logic [$clog2(SINK_TIMEOUT)-1:0] idle_cnt;

	// Start arrives with the first sample, so req is
	// raised in the same cycle and ack lands in time
	assign req    = start | req_q;
	assign accept = in_valid & (active | start);
	// in_sop restarts at word 0
	assign addr   = in_sop ? '0 : cnt;
	assign we     = wr_pend & ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			fin      <= 1'b0;
			req_q    <= 1'b0;
			wr_pend  <= 1'b0;
			cnt      <= '0;
			idle_cnt <= '0;
			done     <= 1'b0;
			abort    <= 1'b0;
		end else begin
			done  <= 1'b0;
			abort <= 1'b0;
			if (start) begin
				req_q <= 1'b1;
				fin   <= 1'b0;
			end
			if (accept) begin
				wr_pend  <= 1'b1;
				cnt      <= addr + 1'b1;
				idle_cnt <= '0;
				// Last word closes the frame
				active   <= ~(&addr);
				fin      <= &addr;
			end else begin
				wr_pend <= wr_pend & ~ack;
				if (active) begin
					idle_cnt <= idle_cnt + 1'b1;
					// Gap too long, give the frame up
					if (int'(idle_cnt) == SINK_TIMEOUT - 1) begin
						active <= 1'b0;
						req_q  <= 1'b0;
						abort  <= 1'b1;
					end
				end
			end
			// Final write issued, release the RAM
			if (fin && we) begin
				fin   <= 1'b0;
				req_q <= 1'b0;
				done  <= 1'b1;
			end
		end
	end

	// Payload registers, written one edge after accept
	always_ff @(posedge clk) begin
		if (accept) begin
			waddr <= addr;
			wdata <= {{(WORD_W-IN_W){in_data[IN_W-1]}}, in_data};
		end
	end

endmodule

// ==== wht_stage_engine.sv ====
//------------------------------------------------
// Stage engine. Four in-place radix-2 passes with
// span 1, 2, 4, 8. Each pair is read low then high
// and written back as sum and difference.
//------------------------------------------------
`timescale 1ns/1ps

module wht_stage_engine (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output logic               req,
	input  logic               ack,
	output wht_mem_pkg::addr_t raddr,
	input  wht_mem_pkg::word_t rdata,
	output logic               we,
	output wht_mem_pkg::addr_t waddr,
	output wht_mem_pkg::word_t wdata,
	output logic               done
);

	import wht_mem_pkg::*;

	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_WAIT,
		ENG_RD_LO,
		ENG_RD_HI,
		ENG_WR_SUM,
		ENG_WR_DIF
	} eng_state_t;

	eng_state_t st;

	// Current pass and pair within the pass
	logic [$clog2(N_STAGES)-1:0] stage;
	logic [ADDR_W-2:0]           pair;

	addr_t span;
	addr_t mask;
	addr_t pair_ext;
	addr_t lo_addr;
	addr_t hi_addr;

	// Captured operands
	word_t lo_q;
	word_t hi_q;

	//------------------------------------------------
	// Pair addressing
	//------------------------------------------------
	// Insert a zero at bit position stage of pair
	always_comb begin
		span     = addr_t'(1) << stage;
		mask     = span - addr_t'(1);
		pair_ext = addr_t'(pair);
		lo_addr  = ((pair_ext & ~mask) << 1) | (pair_ext & mask);
		hi_addr  = lo_addr | span;
	end

	assign raddr = (st == ENG_RD_HI) ? hi_addr : lo_addr;
	assign waddr = (st == ENG_WR_DIF) ? hi_addr : lo_addr;
	assign we    = (st == ENG_WR_SUM) || (st == ENG_WR_DIF);
	// High word is on rdata during the sum cycle
	assign wdata = (st == ENG_WR_DIF) ? lo_q - hi_q : lo_q + rdata;

	//------------------------------------------------
	// Sequencing
	//------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st    <= ENG_IDLE;
			req   <= 1'b0;
			done  <= 1'b0;
			stage <= '0;
			pair  <= '0;
		end else begin
			done <= 1'b0;
			case (st)
				ENG_IDLE: begin
					if (start) begin
						req   <= 1'b1;
						stage <= '0;
						pair  <= '0;
						st    <= ENG_WAIT;
					end
				end
				ENG_WAIT: begin
					if (ack) begin
						st <= ENG_RD_LO;
					end
				end
				ENG_RD_LO:  st <= ENG_RD_HI;
				ENG_RD_HI:  st <= ENG_WR_SUM;
				ENG_WR_SUM: st <= ENG_WR_DIF;
				ENG_WR_DIF: begin
					pair <= pair + 1'b1;
					st   <= ENG_RD_LO;
					if (&pair) begin
						if (int'(stage) == N_STAGES - 1) begin
							// Last butterfly written
							req  <= 1'b0;
							done <= 1'b1;
							st   <= ENG_IDLE;
						end else begin
							stage <= stage + 1'b1;
						end
					end
				end
				default: st <= ENG_IDLE;
			endcase
		end
	end

	// Operand capture
	always_ff @(posedge clk) begin
		if (st == ENG_RD_HI) begin
			lo_q <= rdata;
		end
		if (st == ENG_WR_SUM) begin
			hi_q <= rdata;
		end
	end

endmodule

// ==== wht_source.sv ====
//------------------------------------------------
// Source reader. Streams the 16 results out in
// natural order, one word per cycle, with out_sop
// on word 0.
//------------------------------------------------
`timescale 1ns/1ps

module wht_source (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output logic               req,
	input  logic               ack,
	output wht_mem_pkg::addr_t raddr,
	input  wht_mem_pkg::word_t rdata,
	output logic               out_valid,
	output logic               out_sop,
	output wht_mem_pkg::word_t out_data,
	output logic               done
);

	import wht_mem_pkg::*;

	typedef enum logic [1:0] {
		SRC_IDLE,
		SRC_WAIT,
		SRC_READ
	} src_state_t;

	src_state_t st;
	addr_t      cnt;
	// Read issued last cycle, data now on rdata
	logic       rd_v;
	logic       rd_first;

	assign raddr = cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st        <= SRC_IDLE;
			req       <= 1'b0;
			done      <= 1'b0;
			cnt       <= '0;
			rd_v      <= 1'b0;
			rd_first  <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
		end else begin
			done      <= 1'b0;
			// Two-stage valid to follow RAM and output register
			rd_v      <= (st == SRC_READ);
			rd_first  <= (st == SRC_READ) && (cnt == '0);
			out_valid <= rd_v;
			out_sop   <= rd_first;
			case (st)
				SRC_IDLE: begin
					if (start) begin
						req <= 1'b1;
						st  <= SRC_WAIT;
					end
				end
				SRC_WAIT: begin
					cnt <= '0;
					if (ack) begin
						st <= SRC_READ;
					end
				end
				SRC_READ: begin
					cnt <= cnt + 1'b1;
					if (&cnt) begin
						req  <= 1'b0;
						done <= 1'b1;
						st   <= SRC_IDLE;
					end
				end
				default: st <= SRC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		out_data <= rdata;
	end

endmodule

// ==== wht_mem_top.sv ====
//------------------------------------------------
// WHT data memory top. Phase sequencer over sink,
// stage engine and source, which share one RAM
// through the arbiter. sink_ready gates frame start.
//------------------------------------------------
`timescale 1ns/1ps

module wht_mem_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic                    in_sop,
	input  wht_mem_pkg::in_sample_t in_data,
	output logic                    sink_ready,
	output logic                    out_valid,
	output logic                    out_sop,
	output wht_mem_pkg::word_t      out_data
);

	import wht_mem_pkg::*;

	seq_state_t state;

	logic  sink_start, eng_start, src_start;
	logic  sink_done, sink_abort, eng_done, src_done;
	logic  sink_req, sink_ack, sink_we;
	logic  eng_req, eng_ack, eng_we;
	logic  src_req, src_ack;
	addr_t sink_waddr, eng_waddr, eng_raddr, src_raddr;
	word_t sink_wdata, eng_wdata;

	// RAM port
	logic  ram_we;
	addr_t ram_waddr, ram_raddr;
	word_t ram_wdata, ram_rdata;

	//------------------------------------------------
	// Phase sequencer
	//------------------------------------------------
	// Frame opens on sop while idle and ready
	assign sink_start = (state == IDLE) && sink_ready && in_valid && in_sop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			eng_start  <= 1'b0;
			src_start  <= 1'b0;
			sink_ready <= 1'b1;
		end else begin
			eng_start  <= 1'b0;
			src_start  <= 1'b0;
			sink_ready <= (state == IDLE);
			case (state)
				IDLE:   if (sink_start) state <= SINK;
				SINK: begin
					if (sink_done) begin
						state     <= STAGES;
						eng_start <= 1'b1;
					end else if (sink_abort) begin
						// Partial frame dropped
						state <= IDLE;
					end
				end
				STAGES: begin
					if (eng_done) begin
						state     <= SOURCE;
						src_start <= 1'b1;
					end
				end
				SOURCE: if (src_done) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	//------------------------------------------------
	// Peers
	//------------------------------------------------
	wht_sink i_sink (
		.clk(clk), .rst_n(rst_n), .start(sink_start),
		.in_valid(in_valid), .in_sop(in_sop), .in_data(in_data),
		.req(sink_req), .ack(sink_ack), .we(sink_we),
		.waddr(sink_waddr), .wdata(sink_wdata),
		.done(sink_done), .abort(sink_abort)
	);

	wht_stage_engine i_engine (
		.clk(clk), .rst_n(rst_n), .start(eng_start),
		.req(eng_req), .ack(eng_ack), .raddr(eng_raddr), .rdata(ram_rdata),
		.we(eng_we), .waddr(eng_waddr), .wdata(eng_wdata), .done(eng_done)
	);

	wht_source i_source (
		.clk(clk), .rst_n(rst_n), .start(src_start),
		.req(src_req), .ack(src_ack), .raddr(src_raddr), .rdata(ram_rdata),
		.out_valid(out_valid), .out_sop(out_sop), .out_data(out_data),
		.done(src_done)
	);

	//------------------------------------------------
	// Arbiter and RAM
	//------------------------------------------------
	// Sink never reads, source never writes
	wht_mem_arbiter i_arbiter (
		.clk(clk), .rst_n(rst_n),
		.sink_req(sink_req), .sink_ack(sink_ack), .sink_we(sink_we),
		.sink_waddr(sink_waddr), .sink_wdata(sink_wdata), .sink_raddr('0),
		.eng_req(eng_req), .eng_ack(eng_ack), .eng_we(eng_we),
		.eng_waddr(eng_waddr), .eng_wdata(eng_wdata), .eng_raddr(eng_raddr),
		.src_req(src_req), .src_ack(src_ack), .src_we(1'b0),
		.src_waddr('0), .src_wdata('0), .src_raddr(src_raddr),
		.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata), .raddr(ram_raddr)
	);

	wht_sample_ram i_ram (
		.clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.raddr(ram_raddr), .rdata(ram_rdata)
	);

endmodule

// ==== tb_wht_mem.sv ====
//------------------------------------------------
// Testbench for the WHT data memory top. Applies a
// table of frames, predicts each transform with a
// direct sum model and checks the output stream.
//------------------------------------------------
`timescale 1ns/1ps

module tb_wht_mem;

	import wht_mem_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	// Cycle budget for one frame from sink to source
	localparam int FRAME_BOUND  = 400;

	typedef enum int {
		K_IMPULSE,
		K_CONST,
		K_MAX,
		K_MIN,
		K_ALT,
		K_LFSR,
		K_TRUNC
	} frame_kind_t;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic       in_sop;
	in_sample_t in_data;
	logic       sink_ready;
	logic       out_valid;
	logic       out_sop;
	word_t      out_data;

	// Frame case table
	string       case_name [$];
	frame_kind_t case_kind [$];
	bit          case_gaps [$];

	logic [15:0] lfsr_state;
	in_sample_t  smp [N_PTS];
	// Output words collected by the monitor
	word_t       got [N_PTS];
	int          n_got;
	string       cur_name;

	wht_mem_top i_dut (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sop(in_sop),
		.in_data(in_data), .sink_ready(sink_ready), .out_valid(out_valid),
		.out_sop(out_sop), .out_data(out_data)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	//------------------------------------------------
	// Stimulus helpers and reference model
	//------------------------------------------------
	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One step per bit taken
	// First bit lands in the MSB
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[15]};
			lfsr_state = next_lfsr(lfsr_state);
		end
		return v;
	endfunction

	// Sum of all samples with sign flipped where n AND k has odd parity
	function automatic word_t expected_word(input int k);
		int          acc;
		logic [ADDR_W-1:0] nk;
		acc = 0;
		for (int n = 0; n < N_PTS; n++) begin
			nk = ADDR_W'(n & k);
			if (^nk) begin
				acc -= int'(smp[n]);
			end else begin
				acc += int'(smp[n]);
			end
		end
		return word_t'(acc);
	endfunction

	task automatic add_case(input string name, input frame_kind_t kind, input bit gaps);
		case_name.push_back(name);
		case_kind.push_back(kind);
		case_gaps.push_back(gaps);
	endtask

	task automatic fill_frame(input frame_kind_t kind);
		for (int n = 0; n < N_PTS; n++) begin
			case (kind)
				K_IMPULSE: smp[n] = (n == 0) ? in_sample_t'(1) : in_sample_t'(0);
				K_CONST:   smp[n] = in_sample_t'(1000);
				K_MAX:     smp[n] = in_sample_t'(32767);
				K_MIN:     smp[n] = in_sample_t'(-32768);
				K_ALT:     smp[n] = n[0] ? in_sample_t'(-32768) : in_sample_t'(32767);
				default:   smp[n] = in_sample_t'(random_bits(IN_W));
			endcase
		end
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s: expected %0d, actual %0d", what, exp, act));
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s: expected %b, actual %b", what, exp, act));
		end
	endtask

	// Drive n_samples of smp with gaps of 0 to 3 idle cycles
	task automatic send_frame(input int n_samples, input bit gaps);
		int idle;
		for (int i = 0; i < n_samples; i++) begin
			if (gaps && i > 0) begin
				idle = int'(random_bits(2));
				in_valid = 1'b0;
				in_sop   = 1'b0;
				repeat (idle) @(negedge clk);
			end
			// Ready drops one cycle after the frame opens
			if (i >= 2) begin
				check_bit($sformatf("%s sink_ready in frame", cur_name), 1'b0, sink_ready);
			end
			in_valid = 1'b1;
			in_sop   = (i == 0);
			in_data  = smp[i];
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
	endtask

	//------------------------------------------------
	// Output monitor
	//------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (n_got >= N_PTS) begin
					stop_with_failure($sformatf("%s gave more than %0d output words",
						cur_name, N_PTS));
				end else begin
					check_bit($sformatf("%s sop word %0d", cur_name, n_got),
						n_got == 0, out_sop);
					check_bit($sformatf("%s sink_ready in output", cur_name),
						1'b0, sink_ready);
					got[n_got] = out_data;
					n_got = n_got + 1;
				end
			end else begin
				check_bit($sformatf("%s sop without valid", cur_name), 1'b0, out_sop);
				// Stream runs on consecutive cycles once started
				if (n_got > 0 && n_got < N_PTS) begin
					stop_with_failure($sformatf("%s output stream broke after %0d words",
						cur_name, n_got));
				end
			end
		end
	end

	// Watchdog sized from the table
	initial begin
		int limit;
		#1;
		limit = RESET_CYCLES + 4 + case_name.size() * FRAME_BOUND;
		repeat (limit) @(posedge clk);
		stop_with_failure($sformatf("timeout, run not finished after %0d cycles", limit));
	end

	//------------------------------------------------
	// Main sequence
	//------------------------------------------------
	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_sop     = 1'b0;
		in_data    = '0;
		n_got      = 0;
		lfsr_state = 16'd76;
		cur_name   = "reset";

		add_case("impulse", K_IMPULSE, 1'b0);
		add_case("constant", K_CONST, 1'b0);
		add_case("max_positive", K_MAX, 1'b0);
		add_case("min_negative", K_MIN, 1'b0);
		add_case("alternating", K_ALT, 1'b0);
		add_case("impulse_gaps", K_IMPULSE, 1'b1);
		add_case("lfsr_gaps", K_LFSR, 1'b1);
		add_case("truncated", K_TRUNC, 1'b0);
		add_case("after_truncation", K_LFSR, 1'b0);
		for (int i = 0; i < 20; i++) begin
			add_case($sformatf("lfsr_%0d", i), K_LFSR, i[0]);
		end

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("reset sink_ready", 1'b1, sink_ready);
		check_bit("reset out_valid", 1'b0, out_valid);

		for (int c = 0; c < case_name.size(); c++) begin
			cur_name = case_name[c];
			fill_frame(case_kind[c]);
			// Next frame waits on ready when sent back to back
			while (!sink_ready) @(negedge clk);
			n_got = 0;
			if (case_kind[c] == K_TRUNC) begin
				send_frame(7, case_gaps[c]);
				// Abandoned frame reopens the sink
				while (!sink_ready) @(negedge clk);
				if (n_got != 0) begin
					stop_with_failure($sformatf("%s: output appeared for an abandoned frame",
						cur_name));
				end
			end else begin
				send_frame(N_PTS, case_gaps[c]);
				while (n_got < N_PTS) begin
					check_bit($sformatf("%s sink_ready busy", cur_name), 1'b0, sink_ready);
					@(negedge clk);
				end
				for (int k = 0; k < N_PTS; k++) begin
					check_word($sformatf("%s word %0d", cur_name, k), expected_word(k), got[k]);
				end
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== wht_mem.f ====
wht_mem_pkg.sv
wht_sample_ram.sv
wht_mem_arbiter.sv
wht_sink.sv
wht_stage_engine.sv
wht_source.sv
wht_mem_top.sv
tb_wht_mem.sv

// ==== Makefile ====
# Verilator build and run for the WHT data memory
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_wht_mem
RTL_TOP   ?= wht_mem_top
FILELIST  ?= wht_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard *.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BIN) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
